// File: hw/adc_pkg.sv
/* Types for the multislope modulation: state encoding, reference mux codes,
   count widths and the result record that the register bank reads back. */

package adc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  localparam int COUNT_W = 24;
  localparam int INT_W   = 32;
  localparam int HIMUX_W = 4;

  // clock lengths and decision counts
  typedef logic [COUNT_W-1:0] count_t;
  // integration length, too long for 24 bits at 20MHz
  typedef logic [INT_W-1:0]   int_count_t;
  // high mux, active low select lines
  typedef logic [HIMUX_W-1:0] himux_t;

  ////////////////////////////////////////////////////////////////////////////
  // modulation states, gaps in the encoding kept from the board firmware

  typedef enum logic [4:0] {
    INIT_START    = 5'd0,
    INIT          = 5'd1,
    FIX_POS_START = 5'd6,
    FIX_POS       = 5'd7,
    VAR_START     = 5'd8,
    VAR           = 5'd9,
    FIX_NEG_START = 5'd10,
    FIX_NEG       = 5'd11,
    VAR2_START    = 5'd12,
    VAR2          = 5'd14,
    RUNDOWN_START = 5'd15,
    RUNDOWN       = 5'd16,
    DONE          = 5'd17
  } mod_state_t;

  // bit 0 drives the p switch, bit 1 the n switch
  typedef enum logic [1:0] {
    MUX_NONE         = 2'b00,
    MUX_REF_POS      = 2'b01,
    MUX_REF_NEG      = 2'b10,
    MUX_REF_SLOW_POS = 2'b11
  } refmux_t;

  // counts from the last conversion
  typedef struct packed {
    count_t count_up;
    count_t count_down;
    count_t clk_count_rundown;
    count_t count_trans_up;
    count_t count_trans_down;
    logic   rundown_dir;
  } result_t;

endpackage

// File: hw/spi_reg_pkg.sv
/* Register map of the SPI bank, frame layout, the configuration record and
   its power-on values. */

package spi_reg_pkg;

  // frame is one address byte then a 24 bit value, msb first
  localparam int ADDR_W  = 8;
  localparam int VAL_W   = 24;
  localparam int FRAME_W = ADDR_W + VAL_W;

  ////////////////////////////////////////////////////////////////////////////
  // register addresses, bit 7 of the address byte is the no-write flag

  localparam logic [ADDR_W-2:0] REG_LED         = 7'd7;
  localparam logic [ADDR_W-2:0] REG_COUNT_UP    = 7'd9;
  localparam logic [ADDR_W-2:0] REG_COUNT_DOWN  = 7'd10;
  localparam logic [ADDR_W-2:0] REG_RUNDOWN     = 7'd11;
  localparam logic [ADDR_W-2:0] REG_TRANS_UP    = 7'd12;
  localparam logic [ADDR_W-2:0] REG_TRANS_DOWN  = 7'd14;
  localparam logic [ADDR_W-2:0] REG_TEST        = 7'd15;
  localparam logic [ADDR_W-2:0] REG_RUNDOWN_DIR = 7'd16;
  localparam logic [ADDR_W-2:0] REG_INIT        = 7'd18;
  localparam logic [ADDR_W-2:0] REG_FIX         = 7'd20;
  localparam logic [ADDR_W-2:0] REG_VAR         = 7'd21;
  localparam logic [ADDR_W-2:0] REG_INT_LO      = 7'd22;
  localparam logic [ADDR_W-2:0] REG_INT_HI      = 7'd23;
  localparam logic [ADDR_W-2:0] REG_SLOW        = 7'd24;
  localparam logic [ADDR_W-2:0] REG_HIMUX       = 7'd25;

  // fixed pattern for link checks
  localparam logic [VAL_W-1:0] TEST_VALUE = 24'hffffff;

  typedef struct packed {
    adc_pkg::count_t     init_n;
    adc_pkg::count_t     fix_n;
    adc_pkg::count_t     var_n;
    adc_pkg::int_count_t int_n;
    logic                use_slow_rundown;
    adc_pkg::himux_t     himux_sel;
  } adc_config_t;

  ////////////////////////////////////////////////////////////////////////////
  // reset values

  localparam adc_pkg::count_t     DEF_INIT  = 24'd10000;
  localparam adc_pkg::count_t     DEF_FIX   = 24'd700;
  localparam adc_pkg::count_t     DEF_VAR   = 24'd5500;
  // 200ms at 20MHz
  localparam adc_pkg::int_count_t DEF_INT   = 32'd4000000;
  localparam logic                DEF_SLOW  = 1'b1;
  // ref lo / agnd selected
  localparam adc_pkg::himux_t     DEF_HIMUX = 4'b1011;
  localparam logic [2:0]          DEF_LED   = 3'b101;

endpackage

// File: hw/spi_slave.sv
/* SPI slave oversampled in the clk domain. Requests read data after the
   address byte and strobes a write when chip select ends a 32 bit frame. */

`timescale 1ns/1ns

module spi_slave (
  input  logic            clk,
  input  logic            reset,
  input  logic            sck,
  input  logic            cs,
  input  logic            mosi,
  output logic            miso,
  output logic            rd_req,
  output logic [6:0]      rd_addr,
  input  adc_pkg::count_t rd_data,
  output logic            wr_en,
  output logic [6:0]      wr_addr,
  output adc_pkg::count_t wr_val
);
  import spi_reg_pkg::*;

  // two flop synchronizers on the pins
  logic [1:0]         sck_sync;
  logic [1:0]         cs_sync;
  logic [1:0]         mosi_sync;
  // previous synced levels for edge detect
  logic               sck_d;
  logic               cs_d;
  logic               sck_fall;
  logic               cs_rise;
  logic               cs_active;
  // saturates so an overlong frame never matches 32
  logic [5:0]         bit_cnt;
  logic [FRAME_W-1:0] shift_in;
  logic [FRAME_W-1:0] shift_out;

  assign sck_fall  = sck_d & ~sck_sync[1];
  assign cs_rise   = cs_sync[1] & ~cs_d;
  assign cs_active = ~cs_sync[1];

  // low 7 bits of the address byte, valid with rd_req
  assign rd_addr = shift_in[ADDR_W-2:0];
  assign miso    = shift_out[FRAME_W-1] & cs_active;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
      sck_d     <= 1'b0;
      cs_d      <= 1'b1;
      bit_cnt   <= '0;
      rd_req    <= 1'b0;
      wr_en     <= 1'b0;
    end
    else
    begin
      sck_sync  <= {sck_sync[0], sck};
      cs_sync   <= {cs_sync[0], cs};
      mosi_sync <= {mosi_sync[0], mosi};
      sck_d     <= sck_sync[1];
      cs_d      <= cs_sync[1];
      if (!cs_active)
        bit_cnt <= '0;
      else if (sck_fall && bit_cnt != '1)
        bit_cnt <= bit_cnt + 6'd1;
      // eighth bit just shifted in
      rd_req <= cs_active && sck_fall && bit_cnt == 6'(ADDR_W - 1);
      // high address bit set means read only
      wr_en  <= cs_rise && bit_cnt == 6'(FRAME_W) && !shift_in[FRAME_W-1];
    end
  end

  // frame data path
  always_ff @(posedge clk)
  begin
    if (cs_active && sck_fall)
      shift_in <= {shift_in[FRAME_W-2:0], mosi_sync[1]};
    if (!cs_active)
      shift_out <= '0;
    else if (rd_req)
      shift_out <= {rd_data, {ADDR_W{1'b0}}};
    else if (sck_fall)
      shift_out <= shift_out << 1;
    if (cs_rise)
    begin
      wr_addr <= shift_in[FRAME_W-2 -: ADDR_W-1];
      wr_val  <= shift_in[VAL_W-1:0];
    end
  end

endmodule

// File: hw/reg_file.sv
/* Configuration and result registers behind the SPI slave. Writes land one
   field at a time, reads are decoded combinationally in the request cycle. */

`timescale 1ns/1ns

module reg_file (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [6:0]               rd_addr,
  input  logic [6:0]               wr_addr,
  output adc_pkg::count_t          rd_data,
  input  logic                     wr_en,
  input  adc_pkg::count_t          wr_val,
  input  adc_pkg::result_t         result,
  output spi_reg_pkg::adc_config_t cfg,
  output logic [2:0]               led
);
  import adc_pkg::*;
  import spi_reg_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // write side

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cfg <= '{init_n: DEF_INIT, fix_n: DEF_FIX, var_n: DEF_VAR, int_n: DEF_INT,
               use_slow_rundown: DEF_SLOW, himux_sel: DEF_HIMUX};
      led <= DEF_LED;
    end
    else if (wr_en)
    begin
      case (wr_addr)
        REG_LED:   led                  <= wr_val[2:0];
        REG_INIT:  cfg.init_n           <= wr_val;
        REG_FIX:   cfg.fix_n            <= wr_val;
        REG_VAR:   cfg.var_n            <= wr_val;
        // integration count split over two registers
        REG_INT_LO: cfg.int_n[23:0]     <= wr_val;
        REG_INT_HI: cfg.int_n[31:24]    <= wr_val[7:0];
        REG_SLOW:  cfg.use_slow_rundown <= wr_val[0];
        REG_HIMUX: cfg.himux_sel        <= wr_val[3:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side, zero extended to 24 bits

  always_comb
  begin
    case (rd_addr)
      REG_LED:         rd_data = count_t'(led);
      REG_COUNT_UP:    rd_data = result.count_up;
      REG_COUNT_DOWN:  rd_data = result.count_down;
      REG_RUNDOWN:     rd_data = result.clk_count_rundown;
      REG_TRANS_UP:    rd_data = result.count_trans_up;
      REG_TRANS_DOWN:  rd_data = result.count_trans_down;
      REG_TEST:        rd_data = TEST_VALUE;
      REG_RUNDOWN_DIR: rd_data = count_t'(result.rundown_dir);
      REG_INIT:        rd_data = cfg.init_n;
      REG_FIX:         rd_data = cfg.fix_n;
      REG_VAR:         rd_data = cfg.var_n;
      REG_INT_LO:      rd_data = cfg.int_n[23:0];
      REG_INT_HI:      rd_data = count_t'(cfg.int_n[31:24]);
      REG_SLOW:        rd_data = count_t'(cfg.use_slow_rundown);
      REG_HIMUX:       rd_data = count_t'(cfg.himux_sel);
      // unmapped reads as zero
      default:         rd_data = '0;
    endcase
  end

endmodule

// File: hw/modulation_fsm.sv
/* Multislope modulation sequencer. Drives the reference and input muxes from
   the phase lengths in cfg and tells the counters when phases start. */

`timescale 1ns/1ns

module modulation_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     comparator,
  input  spi_reg_pkg::adc_config_t cfg,
  output adc_pkg::refmux_t         refmux,
  output logic                     sigmux,
  output adc_pkg::himux_t          himux,
  output logic                     clear,
  output logic                     phase_set,
  output logic                     latch,
  output adc_pkg::refmux_t         next_ref,
  output adc_pkg::count_t          rundown_count
);
  import adc_pkg::*;
  import spi_reg_pkg::*;

  // three flop comparator synchronizer, fourth stage only for edge detect
  logic [3:0] cmp_sync;
  logic       cmp_level;
  logic       cross_any;
  mod_state_t state;
  // clocks in the current phase
  count_t     phase_cnt;
  // clocks since start of signal integration
  int_count_t int_cnt;
  logic       done;
  // reference for a variable phase, pushes integrator back toward zero
  refmux_t    var_ref;

  assign cmp_level = cmp_sync[2];
  assign cross_any = cmp_sync[3] ^ cmp_sync[2];
  assign var_ref   = cmp_level ? MUX_REF_NEG : MUX_REF_POS;
  // signal switch stays off, pin kept for the board
  assign sigmux    = 1'b0;

  always_ff @(posedge clk)
  begin
    if (reset)
      cmp_sync <= '0;
    else
      cmp_sync <= {cmp_sync[2:0], comparator};
  end

  ////////////////////////////////////////////////////////////////////////////
  // sequencer

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= INIT_START;
      phase_cnt <= '0;
      int_cnt   <= '0;
      done      <= 1'b0;
      refmux    <= MUX_NONE;
      himux     <= DEF_HIMUX;
      clear     <= 1'b0;
      phase_set <= 1'b0;
      latch     <= 1'b0;
      next_ref  <= MUX_NONE;
    end
    else
    begin
      phase_cnt <= phase_cnt + 1'b1;
      int_cnt   <= int_cnt + 1'b1;
      clear     <= 1'b0;
      phase_set <= 1'b0;
      latch     <= 1'b0;
      if (int_cnt >= cfg.int_n)
        done <= 1'b1;
      case (state)
        INIT_START:
        begin
          state     <= INIT;
          phase_cnt <= '0;
          int_cnt   <= '0;
          done      <= 1'b0;
          clear     <= 1'b1;
          // input buffer settles to the new selection during init
          himux     <= cfg.himux_sel;
          refmux    <= MUX_NONE;
        end
        INIT:
          if (phase_cnt == cfg.init_n)
            state <= FIX_POS_START;
        FIX_POS_START:
        begin
          state     <= FIX_POS;
          phase_cnt <= '0;
          refmux    <= MUX_REF_POS;
          next_ref  <= MUX_REF_POS;
          phase_set <= 1'b1;
        end
        FIX_POS:
          if (phase_cnt == cfg.fix_n)
            state <= VAR_START;
        VAR_START:
        begin
          state     <= VAR;
          phase_cnt <= '0;
          refmux    <= var_ref;
          next_ref  <= var_ref;
          phase_set <= 1'b1;
        end
        VAR:
          if (phase_cnt == cfg.var_n)
            state <= FIX_NEG_START;
        FIX_NEG_START:
        begin
          state     <= FIX_NEG;
          phase_cnt <= '0;
          refmux    <= MUX_REF_NEG;
          next_ref  <= MUX_REF_NEG;
          phase_set <= 1'b1;
        end
        FIX_NEG:
          if (phase_cnt == cfg.fix_n)
            state <= VAR2_START;
        VAR2_START:
        begin
          state     <= VAR2;
          phase_cnt <= '0;
          refmux    <= var_ref;
          next_ref  <= var_ref;
          phase_set <= 1'b1;
        end
        VAR2:
          // integration over and on the low side, go to rundown
          if (phase_cnt == cfg.var_n)
            state <= (done && !cmp_level) ? RUNDOWN_START : FIX_POS_START;
        RUNDOWN_START:
        begin
          state     <= RUNDOWN;
          phase_cnt <= '0;
          refmux    <= cfg.use_slow_rundown ? MUX_REF_SLOW_POS : MUX_REF_POS;
          next_ref  <= cfg.use_slow_rundown ? MUX_REF_SLOW_POS : MUX_REF_POS;
          phase_set <= 1'b1;
        end
        RUNDOWN:
          // either cross edge ends it
          if (cross_any)
          begin
            state  <= DONE;
            refmux <= MUX_NONE;
            latch  <= 1'b1;
          end
        DONE:
          state <= INIT_START;
        default:
          state <= INIT_START;
      endcase
    end
  end

  // rundown length, valid with latch
  always_ff @(posedge clk)
  begin
    if (state == RUNDOWN && cross_any)
      rundown_count <= phase_cnt;
  end

endmodule

// File: hw/run_counters.sv
/* Decision and reference transition counters for one conversion. Results are
   captured at the end of rundown and signalled with an active low interrupt. */

`timescale 1ns/1ns

module run_counters (
  input  logic             clk,
  input  logic             reset,
  input  logic             clear,
  input  logic             phase_set,
  input  logic             latch,
  input  adc_pkg::refmux_t next_ref,
  input  adc_pkg::count_t  rundown_count,
  output adc_pkg::result_t result,
  output logic             int_n
);
  import adc_pkg::*;

  count_t  count_up;
  count_t  count_down;
  count_t  trans_up;
  count_t  trans_down;
  // reference currently on the integrator
  refmux_t held_ref;
  // set when the next phase start is a variable one
  logic    var_phase;

  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      count_up   <= '0;
      count_down <= '0;
      trans_up   <= '0;
      trans_down <= '0;
      held_ref   <= MUX_NONE;
      var_phase  <= 1'b0;
    end
    else if (phase_set)
    begin
      held_ref  <= next_ref;
      // fixed and variable phases alternate, rundown lands on fixed
      var_phase <= ~var_phase;
      if (var_phase && next_ref == MUX_REF_NEG)
        count_up <= count_up + 1'b1;
      if (var_phase && next_ref == MUX_REF_POS)
        count_down <= count_down + 1'b1;
      // slow rundown code is not a transition
      if (next_ref != held_ref && next_ref == MUX_REF_NEG)
        trans_up <= trans_up + 1'b1;
      if (next_ref != held_ref && next_ref == MUX_REF_POS)
        trans_down <= trans_down + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      result <= '0;
      int_n  <= 1'b1;
    end
    else
    begin
      // one clock low, the cycle after latch
      int_n <= ~latch;
      if (latch)
        result <= '{count_up: count_up, count_down: count_down,
                    clk_count_rundown: rundown_count, count_trans_up: trans_up,
                    count_trans_down: trans_down,
                    rundown_dir: held_ref == MUX_REF_NEG};
    end
  end

endmodule

// File: hw/multislope_adc.sv
/* Top level of the multislope ADC controller. Connects the SPI slave, the
   register bank, the sequencer and the counters to the board pins. */

`timescale 1ns/1ns

module multislope_adc (
  input  logic       clk,
  input  logic       reset,
  output logic [2:0] led,
  output logic       int_in_p,
  output logic       int_in_n,
  output logic       int_in_sig,
  output logic       mux_sig_hi,
  output logic       mux_ref_hi,
  output logic       mux_ref_lo,
  output logic       mux_slope_ang,
  input  logic       cmpr_out,
  input  logic       com_clk,
  input  logic       com_cs,
  input  logic       com_mosi,
  output logic       com_miso,
  output logic       com_interupt
);
  import adc_pkg::*;
  import spi_reg_pkg::*;

  // spi to register bank
  logic [ADDR_W-2:0] rd_addr;
  logic [ADDR_W-2:0] wr_addr;
  count_t            rd_data;
  count_t            wr_val;
  logic              wr_en;
  adc_config_t       cfg;
  result_t           result;
  // sequencer to counters
  logic              clear;
  logic              phase_set;
  logic              latch;
  refmux_t           refmux;
  refmux_t           next_ref;
  himux_t            himux;
  count_t            rundown_count;

  ////////////////////////////////////////////////////////////////////////////
  // pin mapping, same bit order as the board netlist

  assign {int_in_n, int_in_p} = refmux;
  assign {mux_slope_ang, mux_ref_lo, mux_ref_hi, mux_sig_hi} = himux;

  // read mux answers in the same cycle, request strobe not needed outside
  spi_slave u_spi (
    .clk, .reset, .sck(com_clk), .cs(com_cs), .mosi(com_mosi), .miso(com_miso),
    .rd_req(), .rd_addr, .rd_data, .wr_en, .wr_addr, .wr_val
  );

  reg_file u_regs (
    .clk, .reset, .rd_addr, .wr_addr, .rd_data, .wr_en, .wr_val, .result, .cfg, .led
  );

  modulation_fsm u_fsm (
    .clk, .reset, .comparator(cmpr_out), .cfg, .refmux, .sigmux(int_in_sig), .himux,
    .clear, .phase_set, .latch, .next_ref, .rundown_count
  );

  run_counters u_counters (
    .clk, .reset, .clear, .phase_set, .latch, .next_ref, .rundown_count, .result,
    .int_n(com_interupt)
  );

endmodule

// File: test/tb_tasks.svh
/* SPI master transfer, interrupt wait and typed compare tasks, included in
   the testbench module body so they drive its pins and count its errors. */

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// n rising edges, then land 2ns after the last one
task automatic step_clks(input int n);
  repeat (n) @(posedge clk);
  #2;
endtask

////////////////////////////////////////////////////////////////////////////
// spi master, mode with data taken on the falling sck edge

task automatic spi_frame(input logic [7:0] addr, input count_t val,
                         output count_t rdata);
  logic [31:0] frame;
  frame = {addr, val};
  rdata = '0;
  com_cs = 1'b0;
  step_clks(SPI_HALF);
  for (int i = 0; i < 32; i++)
  begin
    step_clks(SPI_HALF);
    // read value shows on miso from the ninth bit on
    if (i >= 8)
      rdata[31-i] = com_miso;
    // mosi changes on the rising edge, held across the fall
    com_clk  = 1'b1;
    com_mosi = frame[31-i];
    step_clks(SPI_HALF);
    com_clk = 1'b0;
  end
  step_clks(SPI_HALF);
  // cs rising commits the write
  com_cs   = 1'b1;
  com_mosi = 1'b0;
  step_clks(SPI_GAP);
endtask

// interrupt is active low and one clock wide
task automatic wait_irq();
  while (com_interupt !== 1'b0)
    step_clks(1);
  step_clks(1);
  checks++;
  if (com_interupt !== 1'b1)
  begin
    errors++;
    $display("ERR %0t: interrupt held low for more than one clock", $time);
  end
endtask

////////////////////////////////////////////////////////////////////////////
// compare tasks

task automatic check_count(input string what, input count_t got, input count_t exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
  end
endtask

task automatic check_dir(input string what, input logic got, input logic exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic check_refmux(input string what, input refmux_t got, input refmux_t exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
  end
endtask

`endif

// File: test/tb_multislope_adc.sv
/* Testbench for the multislope ADC controller. Configures it over SPI from a
   table, models the comparator and checks the conversion results. */

`timescale 1ns/1ns

module tb_multislope_adc;
  import adc_pkg::*;
  import spi_reg_pkg::*;

  localparam int SPI_HALF   = 5;
  localparam int SPI_GAP    = 6;
  localparam int FRAME_CLKS = 66 * SPI_HALF + SPI_GAP;
  // clocks from rundown seen on the pins to the comparator flip
  localparam int CMP_DELAY  = 37;
  localparam int MAX_ROWS   = 32;

  logic       clk;
  logic       reset;
  logic [2:0] led;
  logic       int_in_p;
  logic       int_in_n;
  logic       int_in_sig;
  logic       mux_sig_hi;
  logic       mux_ref_hi;
  logic       mux_ref_lo;
  logic       mux_slope_ang;
  logic       cmpr_out;
  logic       com_clk;
  logic       com_cs;
  logic       com_mosi;
  logic       com_miso;
  logic       com_interupt;

  int         errors;
  int         checks;
  // stimulus table, address byte, value sent, value read back
  logic [7:0] row_addr [MAX_ROWS];
  count_t     row_val  [MAX_ROWS];
  count_t     row_exp  [MAX_ROWS];
  int         n_rows;
  // random configuration
  count_t     fix_r;
  count_t     var_r;
  count_t     lo_r;
  count_t     init_r;
  logic [7:0] hi_r;
  himux_t     him_r;
  logic [2:0] led_r;
  // longest fast pos stretch outside rundown, plus margin
  int         long_pos;
  refmux_t    last_rundown_ref;
  longint     limit_clks;

  `include "tb_tasks.svh"

  multislope_adc DUT (
    .clk(clk), .reset(reset), .led(led), .int_in_p(int_in_p), .int_in_n(int_in_n),
    .int_in_sig(int_in_sig), .mux_sig_hi(mux_sig_hi), .mux_ref_hi(mux_ref_hi),
    .mux_ref_lo(mux_ref_lo), .mux_slope_ang(mux_slope_ang), .cmpr_out(cmpr_out),
    .com_clk(com_clk), .com_cs(com_cs), .com_mosi(com_mosi), .com_miso(com_miso),
    .com_interupt(com_interupt)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic add_row(input logic [7:0] addr, input count_t val, input count_t exp);
    row_addr[n_rows] = addr;
    row_val[n_rows]  = val;
    row_exp[n_rows]  = exp;
    n_rows++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // comparator model, low until rundown, then flips after CMP_DELAY clocks

  initial
  begin : comparator_model
    int pos_run;
    pos_run = 0;
    wait (reset === 1'b0);
    forever
    begin
      step_clks(1);
      if ({int_in_n, int_in_p} == MUX_REF_POS)
        pos_run++;
      else
        pos_run = 0;
      // fast rundown only shows as an overlong pos stretch
      if ({int_in_n, int_in_p} == MUX_REF_SLOW_POS || pos_run == long_pos)
      begin
        last_rundown_ref = refmux_t'({int_in_n, int_in_p});
        step_clks(CMP_DELAY);
        cmpr_out = 1'b1;
        // back low during the next init
        step_clks(8);
        cmpr_out = 1'b0;
        pos_run  = 0;
      end
    end
  end

  // watchdog
  initial
  begin
    #1;
    #(limit_clks * 20);
    $display("watchdog expired after %0d clocks, the run did not complete", limit_clks);
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    count_t rd;
    count_t up;
    count_t down;
    count_t rdown;
    count_t tup;
    count_t tdown;
    count_t dir;
    reset    = 1'b1;
    cmpr_out = 1'b0;
    com_clk  = 1'b0;
    com_cs   = 1'b1;
    com_mosi = 1'b0;
    errors   = 0;
    checks   = 0;
    n_rows   = 0;
    last_rundown_ref = MUX_NONE;
    void'($urandom(32'h16f9));
    fix_r  = count_t'(20 + $urandom % 40);
    var_r  = count_t'(20 + $urandom % 40);
    lo_r   = count_t'(1500 + $urandom % 1000);
    // above the init count reached when this write lands
    init_r = count_t'(9300 + $urandom % 400);
    hi_r   = 8'(1 + $urandom % 255);
    // always differs from the reset value
    him_r  = DEF_HIMUX ^ himux_t'(1 + $urandom % 15);
    led_r  = DEF_LED ^ 3'(1 + $urandom % 7);
    long_pos   = 2 * int'(var_r) + int'(fix_r) + 10;
    limit_clks = 16 + (MAX_ROWS + 24) * FRAME_CLKS
                 + 4 * (int'(init_r) + int'(lo_r) + 4 * long_pos + 200);

    // defaults, read only frames
    add_row({1'b1, REG_INIT}, '0, DEF_INIT);
    add_row({1'b1, REG_FIX}, '0, DEF_FIX);
    add_row({1'b1, REG_VAR}, '0, DEF_VAR);
    add_row({1'b1, REG_INT_LO}, '0, DEF_INT[23:0]);
    add_row({1'b1, REG_INT_HI}, '0, count_t'(DEF_INT[31:24]));
    add_row({1'b1, REG_SLOW}, '0, count_t'(DEF_SLOW));
    add_row({1'b1, REG_HIMUX}, '0, count_t'(DEF_HIMUX));
    add_row({1'b1, REG_LED}, '0, count_t'(DEF_LED));
    add_row({1'b1, REG_TEST}, '0, TEST_VALUE);
    // test register ignores writes
    add_row({1'b0, REG_TEST}, 24'h123456, TEST_VALUE);
    // a write frame returns the old value
    add_row({1'b0, REG_FIX}, fix_r, DEF_FIX);
    add_row({1'b1, REG_FIX}, 24'h5555, fix_r);
    add_row({1'b1, REG_FIX}, '0, fix_r);
    add_row({1'b0, REG_VAR}, var_r, DEF_VAR);
    add_row({1'b1, REG_VAR}, '0, var_r);
    add_row({1'b0, REG_INT_LO}, lo_r, DEF_INT[23:0]);
    add_row({1'b0, REG_INT_HI}, count_t'(hi_r), count_t'(DEF_INT[31:24]));
    // high half write keeps the low half
    add_row({1'b1, REG_INT_LO}, '0, lo_r);
    add_row({1'b0, REG_INT_HI}, '0, count_t'(hi_r));
    add_row({1'b1, REG_INT_HI}, '0, '0);
    add_row({1'b0, REG_SLOW}, 24'd1, 24'd1);
    add_row({1'b1, REG_SLOW}, '0, 24'd1);
    add_row({1'b0, REG_HIMUX}, count_t'(him_r), count_t'(DEF_HIMUX));
    add_row({1'b1, REG_HIMUX}, '0, count_t'(him_r));
    add_row({1'b0, REG_LED}, count_t'(led_r), count_t'(DEF_LED));
    add_row({1'b1, REG_LED}, '0, count_t'(led_r));
    add_row({1'b0, REG_INIT}, init_r, DEF_INIT);
    add_row({1'b1, REG_INIT}, '0, init_r);

    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    check_count("led pins after reset", count_t'(led), count_t'(DEF_LED));
    check_dir("input switch pin after reset", int_in_sig, 1'b0);

    for (int r = 0; r < n_rows; r++)
    begin
      spi_frame(row_addr[r], row_val[r], rd);
      check_count($sformatf("table row %0d addr %0d", r, row_addr[r][6:0]), rd, row_exp[r]);
    end
    check_count("led pins", count_t'(led), count_t'(led_r));

    ////////////////////////////////////////////////////////////////////////
    // conversion with comparator low and slow rundown

    wait_irq();
    step_clks(4);
    check_count("himux pins",
                count_t'({mux_slope_ang, mux_ref_lo, mux_ref_hi, mux_sig_hi}),
                count_t'(him_r));
    check_dir("input switch pin", int_in_sig, 1'b0);
    spi_frame({1'b1, REG_COUNT_UP}, '0, up);
    spi_frame({1'b1, REG_COUNT_DOWN}, '0, down);
    spi_frame({1'b1, REG_RUNDOWN}, '0, rdown);
    spi_frame({1'b1, REG_TRANS_UP}, '0, tup);
    spi_frame({1'b1, REG_TRANS_DOWN}, '0, tdown);
    spi_frame({1'b1, REG_RUNDOWN_DIR}, '0, dir);
    check_count("count_up", up, '0);
    check_count("count_down against trans_down", down, tdown);
    check_count("count_down against twice trans_up", down, {tup[22:0], 1'b0});
    check_dir("rundown_dir", dir[0], 1'b0);
    check_refmux("slow rundown mux", last_rundown_ref, MUX_REF_SLOW_POS);
    checks++;
    if (down < 24'd2)
    begin
      errors++;
      $display("ERR %0t: count_down is %0d, expected at least 2", $time, down);
    end
    // pin flip reaches cross detect through the synchronizer
    checks++;
    if (rdown < count_t'(CMP_DELAY + 3) || rdown > count_t'(CMP_DELAY + 5))
    begin
      errors++;
      $display("ERR %0t: rundown count %0d outside %0d..%0d", $time, rdown,
               CMP_DELAY + 3, CMP_DELAY + 5);
    end

    // fast rundown
    spi_frame({1'b0, REG_SLOW}, '0, rd);
    wait_irq();
    check_refmux("fast rundown mux", last_rundown_ref, MUX_REF_POS);

    // slow rundown again
    spi_frame({1'b0, REG_SLOW}, 24'd1, rd);
    check_count("slow flag before rewrite", rd, '0);
    wait_irq();
    check_refmux("slow rundown mux again", last_rundown_ref, MUX_REF_SLOW_POS);

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: multislope_adc.f
+incdir+test
hw/adc_pkg.sv
hw/spi_reg_pkg.sv
hw/spi_slave.sv
hw/reg_file.sv
hw/modulation_fsm.sv
hw/run_counters.sv
hw/multislope_adc.sv
test/tb_multislope_adc.sv

// File: Makefile
# Verilator build and run of the multislope ADC testbench
VERILATOR ?= verilator
TOP       ?= tb_multislope_adc
FLIST     ?= multislope_adc.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FLIST)) test/tb_tasks.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
